// File: build.f
source/rv32i_types.sv
source/md_issue_if.sv
source/md_result_if.sv
source/seq_divider.sv
source/fu_div_rem.sv
source/fu_mul.sv
source/md_writeback_arb.sv
source/md_unit.sv
tests/tb_md_unit.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module tb_md_unit -o tb_md_unit &&
./obj_dir/tb_md_unit | grep "Test completed successfully" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: tests/tb_md_unit.sv
`timescale 1ns/1ns

module tb_md_unit;
    import rv32i_types::*;

    localparam int TABLE_ROWS     = 22;
    localparam int RANDOM_OPS     = 40;
    localparam int NUM_TAGS       = 1 << PHYS_REG_BITS;
    localparam int TIMEOUT_CYCLES = (TABLE_ROWS + RANDOM_OPS) * (DIV_LATENCY + 10) + 200;

    logic         clk;
    logic         rst;
    logic         issue;
    mult_div_f3_t issue_funct3;
    word_t        issue_rs1;
    word_t        issue_rs2;
    phys_reg_t    issue_tag;
    logic         wb_hold;
    logic         mul_ready;
    logic         div_ready;
    logic         wb_valid;
    word_t        wb_rd_v;
    phys_reg_t    wb_tag;

    mult_div_f3_t op_f3 [$];  // Directed rows come first and random rows after
    word_t        op_rs1 [$];
    word_t        op_rs2 [$];
    word_t        op_exp [$];

    word_t        sb_exp [NUM_TAGS];  // Scoreboard by tag
    logic         sb_valid [NUM_TAGS];
    logic         sb_is_div [NUM_TAGS];
    int           pending_count;
    int           cycle_count = 0;
    integer       seed;
    logic         prev_held;
    phys_reg_t    prev_tag;
    word_t        prev_rd;

    md_unit u_md_unit (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .issue_funct3 (issue_funct3),
        .issue_rs1    (issue_rs1),
        .issue_rs2    (issue_rs2),
        .issue_tag    (issue_tag),
        .wb_hold      (wb_hold),
        .mul_ready    (mul_ready),
        .div_ready    (div_ready),
        .wb_valid     (wb_valid),
        .wb_rd_v      (wb_rd_v),
        .wb_tag       (wb_tag)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic add_row(input mult_div_f3_t f3, input word_t rs1, input word_t rs2,
                           input word_t exp);
        op_f3.push_back(f3);
        op_rs1.push_back(rs1);
        op_rs2.push_back(rs2);
        op_exp.push_back(exp);
    endtask

    // RISC-V M-extension result from the ISA rules
    function automatic word_t expected_result(input mult_div_f3_t f3, input word_t a,
                                              input word_t b);
        logic [63:0] prod;
        logic        ovf;
        word_t       res;
        prod = '0;
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        res  = '0;
        case (f3)
            mult_div_f3_mul:    res = a * b;
            mult_div_f3_mulh:   prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            mult_div_f3_mulhsu: prod = $signed({{32{a[31]}}, a}) * $signed({32'b0, b});
            mult_div_f3_mulhu:  prod = {32'b0, a} * {32'b0, b};
            mult_div_f3_div: begin
                if (b == 0) begin
                    res = '1;
                end else if (ovf) begin
                    res = a;
                end else begin
                    res = $signed(a) / $signed(b);
                end
            end
            mult_div_f3_divu:   res = (b == 0) ? '1 : a / b;
            mult_div_f3_rem: begin
                if (b == 0) begin
                    res = a;
                end else if (ovf) begin
                    res = '0;
                end else begin
                    res = $signed(a) % $signed(b);
                end
            end
            mult_div_f3_remu:   res = (b == 0) ? a : a % b;
        endcase
        if (f3 inside {mult_div_f3_mulh, mult_div_f3_mulhsu, mult_div_f3_mulhu}) begin
            res = prod[63:32];
        end
        return res;
    endfunction

    task automatic record_issue(input int idx);
        sb_exp[issue_tag]    = op_exp[idx];
        sb_valid[issue_tag]  = 1'b1;
        sb_is_div[issue_tag] = op_f3[idx][2];
        pending_count++;
    endtask

    // Sampled at the falling edge where outputs are settled
    task automatic check_writeback();
        if (prev_held) begin
            compare_value("wb_valid", word_t'(wb_valid), 32'h1);  // Held result stays
            if (wb_tag == prev_tag) begin
                compare_value("wb_rd_v", wb_rd_v, prev_rd);
            end else if (!(sb_valid[wb_tag] && sb_is_div[wb_tag] && !sb_is_div[prev_tag])) begin
                // Only a divide may take over a held multiply
                compare_value("wb_tag", word_t'(wb_tag), word_t'(prev_tag));
            end
        end
        if (wb_valid && !wb_hold) begin
            if (!sb_valid[wb_tag]) begin
                $display("Writeback for tag %h that was never issued or already retired",
                         wb_tag);
                stop_on_failure();
            end
            compare_value($sformatf("wb_rd_v (tag %h)", wb_tag), wb_rd_v, sb_exp[wb_tag]);
            sb_valid[wb_tag] = 1'b0;
            pending_count--;
        end
        prev_held = wb_valid & wb_hold;
        prev_tag  = wb_tag;
        prev_rd   = wb_rd_v;
    endtask

    task automatic report_outstanding();
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (sb_valid[t]) begin
                $display("Result for tag %0h was never written back", t);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d results outstanding", cycle_count,
                     pending_count);
            report_outstanding();
            stop_on_failure();
        end
    end

    initial begin
        int           op_idx;
        logic         ready_seen;
        logic         accepted;
        word_t        rnd_sel;
        word_t        rnd_a;
        word_t        rnd_b;
        mult_div_f3_t rnd_f3;

        seed          = 49;
        rst          <= 1'b1;
        issue        <= 1'b0;
        issue_funct3 <= mult_div_f3_mul;
        issue_rs1    <= '0;
        issue_rs2    <= '0;
        issue_tag    <= '0;
        wb_hold      <= 1'b0;
        pending_count = 0;
        prev_held     = 1'b0;
        prev_tag      = '0;
        prev_rd       = '0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            sb_valid[t]  = 1'b0;
            sb_is_div[t] = 1'b0;
            sb_exp[t]    = '0;
        end

        add_row(mult_div_f3_div,    32'h0000_0064, 32'h0000_0007, 32'h0000_000e);
        add_row(mult_div_f3_div,    32'hffff_ff9c, 32'h0000_0007, 32'hffff_fff2);
        add_row(mult_div_f3_rem,    32'hffff_ff9c, 32'h0000_0007, 32'hffff_fffe);
        add_row(mult_div_f3_rem,    32'h0000_0064, 32'hffff_fff9, 32'h0000_0002);
        add_row(mult_div_f3_div,    32'h0000_0064, 32'hffff_fff9, 32'hffff_fff2);
        add_row(mult_div_f3_divu,   32'hffff_ff9c, 32'h0000_0007, 32'h2492_4916);
        add_row(mult_div_f3_remu,   32'hffff_ff9c, 32'h0000_0007, 32'h0000_0002);
        add_row(mult_div_f3_div,    32'h1234_5678, 32'h0000_0000, 32'hffff_ffff);
        add_row(mult_div_f3_divu,   32'h1234_5678, 32'h0000_0000, 32'hffff_ffff);
        add_row(mult_div_f3_rem,    32'h8765_4321, 32'h0000_0000, 32'h8765_4321);
        add_row(mult_div_f3_remu,   32'h8765_4321, 32'h0000_0000, 32'h8765_4321);
        add_row(mult_div_f3_div,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        add_row(mult_div_f3_rem,    32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
        add_row(mult_div_f3_mul,    32'h0000_0007, 32'hffff_fffa, 32'hffff_ffd6);
        add_row(mult_div_f3_mulh,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        add_row(mult_div_f3_mulh,   32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000);
        add_row(mult_div_f3_mulhsu, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
        add_row(mult_div_f3_mulhu,  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
        add_row(mult_div_f3_mulh,   32'h8000_0000, 32'h7fff_ffff, 32'hc000_0000);
        add_row(mult_div_f3_mulhsu, 32'h8000_0000, 32'h8000_0000, 32'hc000_0000);
        add_row(mult_div_f3_mul,    32'h1234_5678, 32'h0000_0010, 32'h2345_6780);
        add_row(mult_div_f3_mulhu,  32'h8000_0000, 32'h0000_0002, 32'h0000_0001);

        for (int i = 0; i < RANDOM_OPS; i++) begin
            rnd_sel = $random(seed);
            rnd_a   = $random(seed);
            rnd_b   = $random(seed);
            rnd_f3  = mult_div_f3_t'(rnd_sel[2:0]);
            rnd_b   = rnd_b >> rnd_sel[7:3];  // Spread of divisor sizes
            add_row(rnd_f3, rnd_a, rnd_b, expected_result(rnd_f3, rnd_a, rnd_b));
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value("mul_ready", word_t'(mul_ready), 32'h1);
        compare_value("div_ready", word_t'(div_ready), 32'h1);
        compare_value("wb_valid", word_t'(wb_valid), 32'h0);

        op_idx     = 0;
        ready_seen = 1'b1;
        while (op_idx < op_f3.size()) begin
            @(posedge clk);
            issue        <= ready_seen;
            issue_funct3 <= op_f3[op_idx];
            issue_rs1    <= op_rs1[op_idx];
            issue_rs2    <= op_rs2[op_idx];
            issue_tag    <= phys_reg_t'(op_idx);  // Tags rotate with the row number
            wb_hold      <= (($random(seed) & 3) == 0);
            @(negedge clk);
            check_writeback();
            accepted = issue & (issue_funct3[2] ? div_ready : mul_ready);
            if (accepted) begin
                record_issue(op_idx);
                op_idx++;
            end
            if (op_idx < op_f3.size()) begin
                ready_seen = op_f3[op_idx][2] ? div_ready : mul_ready;
            end
        end

        while (pending_count != 0) begin
            @(posedge clk);
            issue   <= 1'b0;
            wb_hold <= (($random(seed) & 3) == 0);
            @(negedge clk);
            check_writeback();
        end

        // Idle bus catches a result delivered twice
        repeat (20) begin
            @(posedge clk);
            issue   <= 1'b0;
            wb_hold <= 1'b0;
            @(negedge clk);
            check_writeback();
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule : tb_md_unit

// File: source/md_unit.sv
`timescale 1ns/1ns

module md_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue,
    input  rv32i_types::mult_div_f3_t issue_funct3,
    input  rv32i_types::word_t        issue_rs1,
    input  rv32i_types::word_t        issue_rs2,
    input  rv32i_types::phys_reg_t    issue_tag,
    input  logic                      wb_hold,
    output logic                      mul_ready,
    output logic                      div_ready,
    output logic                      wb_valid,
    output rv32i_types::word_t        wb_rd_v,
    output rv32i_types::phys_reg_t    wb_tag
);

    md_issue_if  div_iss ();
    md_issue_if  mul_iss ();
    md_result_if div_res ();
    md_result_if mul_res ();

    logic div_op;
    logic div_busy;
    logic mul_stalled;

    assign div_op = issue_funct3[2];  // Upper half of funct3 is divide or remainder

    // Issue to a unit that is not ready is dropped
    assign div_iss.start  = issue & div_op & div_ready;
    assign div_iss.rs1_v  = issue_rs1;
    assign div_iss.rs2_v  = issue_rs2;
    assign div_iss.funct3 = issue_funct3;
    assign div_iss.tag    = issue_tag;

    assign mul_iss.start  = issue & ~div_op & mul_ready;
    assign mul_iss.rs1_v  = issue_rs1;
    assign mul_iss.rs2_v  = issue_rs2;
    assign mul_iss.funct3 = issue_funct3;
    assign mul_iss.tag    = issue_tag;

    assign div_ready = ~div_busy;
    assign mul_ready = ~mul_stalled;

    fu_div_rem u_div (
        .clk  (clk),
        .rst  (rst),
        .iss  (div_iss.fu),
        .res  (div_res.fu),
        .busy (div_busy)
    );

    fu_mul u_mul (
        .clk     (clk),
        .rst     (rst),
        .iss     (mul_iss.fu),
        .res     (mul_res.fu),
        .stalled (mul_stalled)
    );

    md_writeback_arb u_arb (
        .div_res  (div_res.arb),
        .mul_res  (mul_res.arb),
        .wb_hold  (wb_hold),
        .wb_valid (wb_valid),
        .wb_rd_v  (wb_rd_v),
        .wb_tag   (wb_tag)
    );

endmodule : md_unit

// File: source/md_writeback_arb.sv
`timescale 1ns/1ns

module md_writeback_arb (
    md_result_if.arb               div_res,
    md_result_if.arb               mul_res,
    input  logic                   wb_hold,
    output logic                   wb_valid,
    output rv32i_types::word_t     wb_rd_v,
    output rv32i_types::phys_reg_t wb_tag
);

    logic div_sel;

    // Divider wins since its pending result keeps it from taking new work
    assign div_sel = div_res.valid;

    assign wb_valid = div_res.valid | mul_res.valid;
    assign wb_rd_v  = div_sel ? div_res.rd_v : mul_res.rd_v;
    assign wb_tag   = div_sel ? div_res.tag : mul_res.tag;

    // Bus back-pressure goes to the winner
    assign div_res.hold = wb_hold;

    // Multiplier waits while it loses or the bus holds
    assign mul_res.hold = div_sel | wb_hold;

endmodule : md_writeback_arb

// File: source/fu_mul.sv
`timescale 1ns/1ns

module fu_mul (
    input  logic    clk,
    input  logic    rst,
    md_issue_if.fu  iss,
    md_result_if.fu res,
    output logic    stalled
);
    import rv32i_types::*;

    ext_word_t    a_ext;
    ext_word_t    b_ext;

    logic         s1_valid;
    ext_word_t    s1_a;
    ext_word_t    s1_b;
    phys_reg_t    s1_tag;
    mult_div_f3_t s1_funct3;

    logic         s2_valid;
    logic [65:0]  s2_prod;
    phys_reg_t    s2_tag;
    mult_div_f3_t s2_funct3;

    logic         s3_valid;
    word_t        s3_rd;
    phys_reg_t    s3_tag;

    // Whole pipe freezes while the output is held
    assign stalled = s3_valid & res.hold;

    always_comb begin
        a_ext = {iss.rs1_v[31], iss.rs1_v};
        b_ext = {iss.rs2_v[31], iss.rs2_v};
        case (iss.funct3)
            mult_div_f3_mulhsu: begin
                b_ext = {1'b0, iss.rs2_v};  // Signed by unsigned
            end
            mult_div_f3_mulhu: begin
                a_ext = {1'b0, iss.rs1_v};
                b_ext = {1'b0, iss.rs2_v};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (!stalled) begin
            s1_valid <= iss.start;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stalled) begin
            s1_a      <= a_ext;
            s1_b      <= b_ext;
            s1_tag    <= iss.tag;
            s1_funct3 <= iss.funct3;
            s2_prod   <= $signed(s1_a) * $signed(s1_b);  // 66 bit signed product
            s2_tag    <= s1_tag;
            s2_funct3 <= s1_funct3;
            s3_rd     <= (s2_funct3 == mult_div_f3_mul) ? s2_prod[31:0] : s2_prod[63:32];
            s3_tag    <= s2_tag;
        end
    end

    assign res.valid = s3_valid;
    assign res.rd_v  = s3_rd;
    assign res.tag   = s3_tag;

endmodule : fu_mul

// File: source/fu_div_rem.sv
`timescale 1ns/1ns

module fu_div_rem (
    input  logic    clk,
    input  logic    rst,
    md_issue_if.fu  iss,
    md_result_if.fu res,
    output logic    busy
);
    import rv32i_types::*;

    ext_word_t    a_ext;
    ext_word_t    b_ext;
    ext_word_t    quotient;
    ext_word_t    remainder;
    logic         complete;
    logic         divide_by_0;
    logic         pending;  // Divide running, result not captured yet
    mult_div_f3_t funct3_reg;
    phys_reg_t    tag_reg;
    word_t        dividend_reg;
    word_t        result;
    logic         out_valid;
    word_t        out_rd;

    always_comb begin
        a_ext = {1'b0, iss.rs1_v};
        b_ext = {1'b0, iss.rs2_v};
        case (iss.funct3)
            mult_div_f3_div, mult_div_f3_rem: begin
                a_ext = {iss.rs1_v[31], iss.rs1_v};
                b_ext = {iss.rs2_v[31], iss.rs2_v};
            end
            default: begin
            end
        endcase
    end

    seq_divider u_divider (
        .clk         (clk),
        .rst         (rst),
        .start       (iss.start),
        .a           (a_ext),
        .b           (b_ext),
        .complete    (complete),
        .divide_by_0 (divide_by_0),
        .quotient    (quotient),
        .remainder   (remainder)
    );

    // Zero divisor gives an all ones quotient and the dividend as remainder
    always_comb begin
        if (funct3_reg == mult_div_f3_rem || funct3_reg == mult_div_f3_remu) begin
            result = divide_by_0 ? dividend_reg : remainder[31:0];
        end else begin
            result = divide_by_0 ? '1 : quotient[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (iss.start) begin
                pending <= 1'b1;
            end else if (pending && complete) begin
                pending <= 1'b0;
            end
            if (pending && complete) begin
                out_valid <= 1'b1;
            end else if (!res.hold) begin
                out_valid <= 1'b0;  // Taken by the arbiter
            end
        end
    end

    always_ff @(posedge clk) begin
        if (iss.start) begin
            funct3_reg   <= iss.funct3;
            tag_reg      <= iss.tag;
            dividend_reg <= iss.rs1_v;
        end
        if (pending && complete) begin
            out_rd <= result;
        end
    end

    assign res.valid = out_valid;
    assign res.rd_v  = out_rd;
    assign res.tag   = tag_reg;  // Stable until the next start
    assign busy      = pending | out_valid;

endmodule : fu_div_rem

// File: source/seq_divider.sv
`timescale 1ns/1ns

module seq_divider (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  rv32i_types::ext_word_t a,
    input  rv32i_types::ext_word_t b,
    output logic                   complete,
    output logic                   divide_by_0,
    output rv32i_types::ext_word_t quotient,
    output rv32i_types::ext_word_t remainder
);
    import rv32i_types::*;

    typedef enum logic [1:0] {
        idle,
        busy,
        done
    } div_state_t;

    div_state_t  state;
    logic [5:0]  step;
    logic        neg_q;
    logic        neg_r;
    ext_word_t   divisor;  // Magnitude of b
    ext_word_t   partial;  // Partial remainder
    ext_word_t   shift_q;  // Dividend bits shift out as quotient bits shift in
    logic [33:0] trial;

    // Next dividend bit appended, then divisor taken off
    assign trial = {partial, shift_q[32]} - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= idle;
            step        <= '0;
            divide_by_0 <= 1'b0;
        end else if (start) begin
            state       <= busy;
            step        <= '0;
            divide_by_0 <= (b == '0);
        end else if (state == busy) begin
            step <= step + 6'd1;
            if (step == 6'd32) begin  // 33 steps, one per quotient bit
                state <= done;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            neg_q   <= a[32] ^ b[32];
            neg_r   <= a[32];  // Remainder follows the dividend
            partial <= '0;
            shift_q <= a[32] ? -a : a;
            divisor <= b[32] ? -b : b;
        end else if (state == busy) begin
            if (!trial[33]) begin
                partial <= trial[32:0];
                shift_q <= {shift_q[31:0], 1'b1};
            end else begin
                // Restore by keeping the shifted remainder
                partial <= {partial[31:0], shift_q[32]};
                shift_q <= {shift_q[31:0], 1'b0};
            end
        end
    end

    assign complete  = (state == done);
    assign quotient  = neg_q ? -shift_q : shift_q;
    assign remainder = neg_r ? -partial : partial;

endmodule : seq_divider

// File: source/md_result_if.sv
`timescale 1ns/1ns

interface md_result_if;
    import rv32i_types::*;

    logic      valid;
    word_t     rd_v;
    phys_reg_t tag;
    logic      hold;  // Result must stay put while high

    modport fu (
        output valid, rd_v, tag,
        input  hold
    );

    modport arb (
        input  valid, rd_v, tag,
        output hold
    );

endinterface : md_result_if

// File: source/md_issue_if.sv
`timescale 1ns/1ns

interface md_issue_if;
    import rv32i_types::*;

    logic         start;  // One cycle strobe
    word_t        rs1_v;
    word_t        rs2_v;
    mult_div_f3_t funct3;
    phys_reg_t    tag;

    modport src (
        output start, rs1_v, rs2_v, funct3, tag
    );

    modport fu (
        input start, rs1_v, rs2_v, funct3, tag
    );

endinterface : md_issue_if

// File: source/rv32i_types.sv
package rv32i_types;

    // M-extension funct3 encodings
    typedef enum logic [2:0] {
        mult_div_f3_mul    = 3'b000,
        mult_div_f3_mulh   = 3'b001,
        mult_div_f3_mulhsu = 3'b010,
        mult_div_f3_mulhu  = 3'b011,
        mult_div_f3_div    = 3'b100,
        mult_div_f3_divu   = 3'b101,
        mult_div_f3_rem    = 3'b110,
        mult_div_f3_remu   = 3'b111
    } mult_div_f3_t;

    localparam int PHYS_REG_BITS = 6;

    // Start of a divide to its result valid
    localparam int DIV_LATENCY = 35;

    // Start of a multiply to its result valid without a stall
    localparam int MUL_LATENCY = 3;

    typedef logic [PHYS_REG_BITS-1:0] phys_reg_t;  // Destination tag

    typedef logic [31:0] word_t;

    typedef logic [32:0] ext_word_t;  // Sign or zero extended operand

endpackage : rv32i_types
